//--- design/board_pkg.sv
/* Board package for the side-channel evaluation target
   Pad counts, pin map, engine constants and the pad and JTAG bus structs */

`default_nettype none

package board_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pad counts
  ////////////////////////////////////////////////////////////////////////////

  parameter int NMioPads = 23;
  parameter int NDioPads = 4;

  // MIO pin map
  parameter int MioDataLsb     = 0;
  parameter int MioStart       = 8;
  parameter int MioTrigReq     = 9;
  parameter int MioResultLsb   = 10;
  parameter int MioTrigger     = 18;
  parameter int MioResultValid = 19;
  parameter int MioJtagEn      = 20;
  parameter int MioTrst        = 21;
  parameter int MioSrst        = 22;

  // DIO pin map, serial port or JTAG when strapped
  parameter int DioSck = 0;
  parameter int DioCsb = 1;
  parameter int DioSdi = 2;
  parameter int DioSdo = 3;

  // Engine
  parameter int NumRounds = 8;
  parameter int DataW     = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Bus structs
  ////////////////////////////////////////////////////////////////////////////

  // Drive request toward the pads
  typedef struct packed {
    logic [NMioPads-1:0] out;
    logic [NMioPads-1:0] oe;
  } mio_drive_t;

  typedef struct packed {
    logic [NDioPads-1:0] out;
    logic [NDioPads-1:0] oe;
  } dio_drive_t;

  // JTAG port as seen by the core, resets active low
  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
    logic trst_n;
    logic srst_n;
  } jtag_t;

endpackage : board_pkg

`default_nettype wire

//--- design/jtag_overlay_mux.sv
/* JTAG overlay mux
   Turns the four serial pads into a JTAG port while the strap pin is high */

`timescale 1ns/1ps
`default_nettype none

module jtag_overlay_mux (
  // Pad ring side, inputs
  input  logic [board_pkg::NMioPads-1:0] mio_in_i,
  input  logic [board_pkg::NDioPads-1:0] dio_in_i,
  // Core side, drive requests and JTAG return
  input  board_pkg::mio_drive_t          mio_drive_i,
  input  board_pkg::dio_drive_t          dio_drive_i,
  input  logic                           tdo_i,
  // Toward the pad ring
  output board_pkg::mio_drive_t          mio_drive_o,
  output board_pkg::dio_drive_t          dio_drive_o,
  // Toward the core
  output logic [board_pkg::NMioPads-1:0] mio_in_o,
  output logic [board_pkg::NDioPads-1:0] dio_in_o,
  output board_pkg::jtag_t               jtag_o
);

  // Core-side DIO inputs in JTAG mode, csb is active low so it idles high
  localparam logic [board_pkg::NDioPads-1:0] DioTieOff =
      board_pkg::NDioPads'(1) << board_pkg::DioCsb;

  logic jtag_en;

  assign jtag_en = mio_in_i[board_pkg::MioJtagEn];

  ////////////////////////////////////////////////////////////////////////////
  // Outward path
  ////////////////////////////////////////////////////////////////////////////

  // MIO drive passes through, only the SDO pad is taken over for TDO
  assign mio_drive_o = mio_drive_i;

  always_comb begin
    dio_drive_o = dio_drive_i;
    if (jtag_en) begin
      dio_drive_o.out[board_pkg::DioSdo] = tdo_i;
      dio_drive_o.oe[board_pkg::DioSdo]  = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Inward path
  ////////////////////////////////////////////////////////////////////////////

  // Strap, trst and srst still reach the core
  assign mio_in_o = mio_in_i;
  assign dio_in_o = jtag_en ? DioTieOff : dio_in_i;

  always_comb begin
    if (jtag_en) begin
      jtag_o.tck    = dio_in_i[board_pkg::DioSck];
      jtag_o.tms    = dio_in_i[board_pkg::DioCsb];
      jtag_o.tdi    = dio_in_i[board_pkg::DioSdi];
      jtag_o.trst_n = mio_in_i[board_pkg::MioTrst];
      jtag_o.srst_n = mio_in_i[board_pkg::MioSrst];
    end else begin
      // Port parked, both resets released
      jtag_o.tck    = 1'b0;
      jtag_o.tms    = 1'b0;
      jtag_o.tdi    = 1'b0;
      jtag_o.trst_n = 1'b1;
      jtag_o.srst_n = 1'b1;
    end
  end

endmodule : jtag_overlay_mux

`default_nettype wire

//--- design/key_loader.sv
/* Serial key loader
   Shifts a key byte in on rising serial clock edges and the old key out */

`timescale 1ns/1ps
`default_nettype none

module key_loader (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       sck_i,
  input  logic                       csb_i,
  input  logic                       sdi_i,
  output logic                       sdo_o,
  output logic                       sdo_oe_o,
  output logic [board_pkg::DataW-1:0] key_o
);

  localparam int W = board_pkg::DataW;

  logic         sck_q;
  logic         shift_en;
  logic [W-1:0] key_q;

  // Rising serial clock, only while selected
  assign shift_en = sck_i & ~sck_q & ~csb_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_q <= 1'b0;
    end else begin
      sck_q <= sck_i;
    end
  end

  // MSB first out, new bit into the LSB
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      key_q <= '0;
    end else if (shift_en) begin
      key_q <= {key_q[W-2:0], sdi_i};
    end
  end

  assign sdo_o    = key_q[W-1];
  assign sdo_oe_o = ~csb_i;
  assign key_o    = key_q;

endmodule : key_loader

`default_nettype wire

//--- design/pad_ring.sv
/* Pad ring
   Tristate pad drivers plus two-flop input synchronizers with optional inversion */

`timescale 1ns/1ps
`default_nettype none

module pad_ring #(
  parameter logic [board_pkg::NMioPads-1:0] InvertMio = '0
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  inout  wire  [board_pkg::NMioPads-1:0]    mio_pad_io,
  inout  wire  [board_pkg::NDioPads-1:0]    dio_pad_io,
  input  board_pkg::mio_drive_t             mio_drive_i,
  input  board_pkg::dio_drive_t             dio_drive_i,
  output logic [board_pkg::NMioPads-1:0]    mio_in_o,
  output logic [board_pkg::NDioPads-1:0]    dio_in_o
);

  logic [board_pkg::NMioPads-1:0] mio_meta_q, mio_sync_q;
  logic [board_pkg::NDioPads-1:0] dio_meta_q, dio_sync_q;

  // Output drivers, pad floats when oe is low
  for (genvar i = 0; i < board_pkg::NMioPads; i++) begin : gen_mio_drv
    assign mio_pad_io[i] = mio_drive_i.oe[i] ? mio_drive_i.out[i] : 1'bz;
  end

  for (genvar i = 0; i < board_pkg::NDioPads; i++) begin : gen_dio_drv
    assign dio_pad_io[i] = dio_drive_i.oe[i] ? dio_drive_i.out[i] : 1'bz;
  end

  // Input synchronizers
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mio_meta_q <= '0;
      mio_sync_q <= '0;
      dio_meta_q <= '0;
      dio_sync_q <= '0;
    end else begin
      mio_meta_q <= mio_pad_io;
      mio_sync_q <= mio_meta_q;
      dio_meta_q <= dio_pad_io;
      dio_sync_q <= dio_meta_q;
    end
  end

  // Per-pad polarity on the MIO side only
  assign mio_in_o = mio_sync_q ^ InvertMio;
  assign dio_in_o = dio_sync_q;

endmodule : pad_ring

`default_nettype wire

//--- design/round_engine.sv
/* Round engine
   Toy eight-round keyed permutation of one byte, one round per clock */

`timescale 1ns/1ps
`default_nettype none

module round_engine (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        start_i,
  input  logic [board_pkg::DataW-1:0] data_i,
  input  logic [board_pkg::DataW-1:0] key_i,
  output logic                        busy_o,
  output logic                        done_o,
  output logic [board_pkg::DataW-1:0] result_o
);

  localparam int W    = board_pkg::DataW;
  localparam int RndW = $clog2(board_pkg::NumRounds);

  logic            busy_q;
  logic [RndW-1:0] rnd_q;
  logic [W-1:0]    state_q, key_q, result_q;
  logic [W-1:0]    next_state;
  logic            accept;
  logic            last_round;

  // Starts while busy are dropped
  assign accept     = start_i & ~busy_q;
  assign last_round = busy_q & (rnd_q == RndW'(board_pkg::NumRounds - 1));

  // Rotate left, then mix in key and round number
  assign next_state = {state_q[W-2:0], state_q[W-1]} ^ key_q ^ W'(rnd_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      rnd_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      rnd_q  <= '0;
    end else if (busy_q) begin
      busy_q <= ~last_round;
      rnd_q  <= rnd_q + 1'b1;
    end
  end

  // Datapath
  always_ff @(posedge clk_i) begin
    if (accept) begin
      state_q <= data_i;
      key_q   <= key_i;
    end else if (busy_q) begin
      state_q <= next_state;
    end
  end

  // Loads on the edge that drops busy
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
    end else if (last_round) begin
      result_q <= next_state;
    end
  end

  assign busy_o   = busy_q;
  assign done_o   = last_round;
  assign result_o = result_q;

endmodule : round_engine

`default_nettype wire

//--- design/rst_ctrl.sv
/* Reset controller
   Merges the board reset with the JTAG system reset, synchronous release */

`timescale 1ns/1ps
`default_nettype none

module rst_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic srst_n_i,
  output logic core_rst_n_o
);

  logic       merged_rst_n;
  logic [1:0] rst_sync_q;

  // Either source asserts the core reset
  assign merged_rst_n = rst_n_i & srst_n_i;

  // Assert at once, release after two clocks
  always_ff @(posedge clk_i or negedge merged_rst_n) begin
    if (!merged_rst_n) begin
      rst_sync_q <= 2'b00;
    end else begin
      rst_sync_q <= {rst_sync_q[0], 1'b1};
    end
  end

  assign core_rst_n_o = rst_sync_q[1];

endmodule : rst_ctrl

`default_nettype wire

//--- design/sca_board_top.sv
/* Board-level wrapper of the evaluation target
   Pad ring, JTAG overlay, reset merge and core on one board clock */

`timescale 1ns/1ps
`default_nettype none

module sca_board_top #(
  parameter logic [board_pkg::NMioPads-1:0] InvertMio = '0
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  inout  wire  [board_pkg::NMioPads-1:0] mio_pad_io,
  inout  wire  [board_pkg::NDioPads-1:0] dio_pad_io
);

  logic [board_pkg::NMioPads-1:0] mio_in_pad, mio_in_core;
  logic [board_pkg::NDioPads-1:0] dio_in_pad, dio_in_core;
  board_pkg::mio_drive_t          mio_drive_core, mio_drive_pad;
  board_pkg::dio_drive_t          dio_drive_core, dio_drive_pad;
  board_pkg::jtag_t               jtag;
  logic                           jtag_tdo;
  logic                           core_rst_n;

  pad_ring #(
    .InvertMio (InvertMio)
  ) u_pad_ring (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mio_pad_io  (mio_pad_io),
    .dio_pad_io  (dio_pad_io),
    .mio_drive_i (mio_drive_pad),
    .dio_drive_i (dio_drive_pad),
    .mio_in_o    (mio_in_pad),
    .dio_in_o    (dio_in_pad)
  );

  jtag_overlay_mux u_jtag_overlay_mux (
    .mio_in_i    (mio_in_pad),
    .dio_in_i    (dio_in_pad),
    .mio_drive_i (mio_drive_core),
    .dio_drive_i (dio_drive_core),
    .tdo_i       (jtag_tdo),
    .mio_drive_o (mio_drive_pad),
    .dio_drive_o (dio_drive_pad),
    .mio_in_o    (mio_in_core),
    .dio_in_o    (dio_in_core),
    .jtag_o      (jtag)
  );

  // System reset from the JTAG pins also clears the core
  rst_ctrl u_rst_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .srst_n_i     (jtag.srst_n),
    .core_rst_n_o (core_rst_n)
  );

  sca_core u_sca_core (
    .clk_i       (clk_i),
    .rst_n_i     (core_rst_n),
    .mio_in_i    (mio_in_core),
    .dio_in_i    (dio_in_core),
    .jtag_i      (jtag),
    .mio_drive_o (mio_drive_core),
    .dio_drive_o (dio_drive_core),
    .tdo_o       (jtag_tdo)
  );

endmodule : sca_board_top

`default_nettype wire

//--- design/sca_core.sv
/* Evaluation core
   Pin decode, start detect, result pins, JTAG bypass and capture trigger gating */

`timescale 1ns/1ps
`default_nettype none

module sca_core (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [board_pkg::NMioPads-1:0] mio_in_i,
  input  logic [board_pkg::NDioPads-1:0] dio_in_i,
  input  board_pkg::jtag_t               jtag_i,
  output board_pkg::mio_drive_t          mio_drive_o,
  output board_pkg::dio_drive_t          dio_drive_o,
  output logic                           tdo_o
);

  localparam int W = board_pkg::DataW;

  logic         start_q, start_pulse;
  logic         busy, done;
  logic         result_valid_q;
  logic         trigger;
  logic [W-1:0] key, result;
  logic         sdo, sdo_oe;
  logic         tck_q, bypass_q;

  ////////////////////////////////////////////////////////////////////////////
  // Engine and key
  ////////////////////////////////////////////////////////////////////////////

  assign start_pulse = mio_in_i[board_pkg::MioStart] & ~start_q;

  key_loader u_key_loader (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .sck_i    (dio_in_i[board_pkg::DioSck]),
    .csb_i    (dio_in_i[board_pkg::DioCsb]),
    .sdi_i    (dio_in_i[board_pkg::DioSdi]),
    .sdo_o    (sdo),
    .sdo_oe_o (sdo_oe),
    .key_o    (key)
  );

  round_engine u_round_engine (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .start_i  (start_pulse),
    .data_i   (mio_in_i[board_pkg::MioDataLsb +: W]),
    .key_i    (key),
    .busy_o   (busy),
    .done_o   (done),
    .result_o (result)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_q        <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      start_q <= mio_in_i[board_pkg::MioStart];
      if (start_pulse && !busy) begin
        result_valid_q <= 1'b0;
      end else if (done) begin
        result_valid_q <= 1'b1;
      end
    end
  end

  // Capture trigger only while rounds are actually running
  assign trigger = mio_in_i[board_pkg::MioTrigReq] & busy;

  ////////////////////////////////////////////////////////////////////////////
  // JTAG bypass register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tck_q    <= 1'b0;
      bypass_q <= 1'b0;
    end else begin
      tck_q <= jtag_i.tck;
      if (!jtag_i.trst_n) begin
        bypass_q <= 1'b0;
      end else if (jtag_i.tck && !tck_q) begin
        bypass_q <= jtag_i.tdi;
      end
    end
  end

  assign tdo_o = bypass_q;

  // Pin drive, outputs enabled for result, trigger and result-valid
  always_comb begin
    mio_drive_o = '0;
    mio_drive_o.out[board_pkg::MioResultLsb +: W]  = result;
    mio_drive_o.out[board_pkg::MioTrigger]         = trigger;
    mio_drive_o.out[board_pkg::MioResultValid]     = result_valid_q;
    mio_drive_o.oe[board_pkg::MioResultLsb +: W]   = '1;
    mio_drive_o.oe[board_pkg::MioTrigger]          = 1'b1;
    mio_drive_o.oe[board_pkg::MioResultValid]      = 1'b1;
    dio_drive_o = '0;
    dio_drive_o.out[board_pkg::DioSdo] = sdo;
    dio_drive_o.oe[board_pkg::DioSdo]  = sdo_oe;
  end

endmodule : sca_core

`default_nettype wire

//--- sources.f
design/board_pkg.sv
design/pad_ring.sv
design/jtag_overlay_mux.sv
design/rst_ctrl.sv
design/key_loader.sv
design/round_engine.sv
design/sca_core.sv
design/sca_board_top.sv
tests/sca_board_assertions.sv
tests/tb_sca_board.sv

//--- tests/sca_board_assertions.sv
/* Bound checks on the evaluation target
   Capture window length, busy against result-valid, csb tie-off in JTAG mode */

`timescale 1ns/1ps
`default_nettype none

module sca_board_assertions (
  input logic                           clk_i,
  input logic                           rst_n_i,
  input logic                           busy_i,
  input logic                           jtag_en_i,
  input board_pkg::mio_drive_t          mio_drive_i,
  input logic [board_pkg::NDioPads-1:0] dio_in_i
);

  localparam int Rounds = board_pkg::NumRounds;

  int   fail_cnt = 0;
  logic trigger, result_valid;

  assign trigger      = mio_drive_i.out[board_pkg::MioTrigger];
  assign result_valid = mio_drive_i.out[board_pkg::MioResultValid];

  // One capture window per operation, exactly Rounds cycles
  trigger_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(trigger) |-> trigger [*Rounds] ##1 !trigger)
  else begin
    $error("Trigger window is not %0d cycles long", Rounds);
    fail_cnt++;
  end

  busy_no_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    busy_i |-> !result_valid)
  else begin
    $error("Result-valid high while the engine is busy");
    fail_cnt++;
  end

  // Serial port stays deselected while the pads carry JTAG
  jtag_csb_tied: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    jtag_en_i |-> dio_in_i[board_pkg::DioCsb])
  else begin
    $error("Core sees csb low in JTAG mode");
    fail_cnt++;
  end

endmodule : sca_board_assertions

bind sca_board_top sca_board_assertions u_sca_board_assertions (
  .clk_i       (clk_i),
  .rst_n_i     (core_rst_n),
  .busy_i      (u_sca_core.busy),
  .jtag_en_i   (mio_in_pad[board_pkg::MioJtagEn]),
  .mio_drive_i (mio_drive_core),
  .dio_in_i    (dio_in_core)
);

`default_nettype wire

//--- tests/tb_sca_board.sv
/* Testbench for the board-level evaluation target
   Drives the pads through tristate nets and checks results against a round model */

`timescale 1ns/1ps
`default_nettype none

module tb_sca_board;

  localparam int ClkPeriod = 4;
  localparam int Budget    = 20 * 200 * ClkPeriod;
  localparam int W         = board_pkg::DataW;

  logic                           clk, rst_n;
  logic [board_pkg::NMioPads-1:0] mio_en, mio_val;
  logic [board_pkg::NDioPads-1:0] dio_en, dio_val;
  tri   [board_pkg::NMioPads-1:0] mio_pad;
  tri   [board_pkg::NDioPads-1:0] dio_pad;
  logic [W-1:0]                   model_key, next_key, readback;
  logic                           tdi_bit;
  int                             seed = 7;

  for (genvar i = 0; i < board_pkg::NMioPads; i++) begin : gen_mio_pad
    assign mio_pad[i] = mio_en[i] ? mio_val[i] : 1'bz;
  end

  for (genvar i = 0; i < board_pkg::NDioPads; i++) begin : gen_dio_pad
    assign dio_pad[i] = dio_en[i] ? dio_val[i] : 1'bz;
  end

  sca_board_top #(
    .InvertMio ('0)
  ) uut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .mio_pad_io (mio_pad),
    .dio_pad_io (dio_pad)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  // Reference rounds, rotate left then XOR key and round number
  function automatic logic [W-1:0] model_rounds(input logic [W-1:0] din,
                                                input logic [W-1:0] k);
    logic [W-1:0] s;
    s = din;
    for (int r = 0; r < board_pkg::NumRounds; r++) begin
      s = {s[W-2:0], s[W-1]} ^ k ^ W'(r);
    end
    return s;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // MSB first, the old key comes back on sdo
  task automatic shift_key(input logic [W-1:0] new_key, output logic [W-1:0] old_key);
    dio_val[board_pkg::DioCsb] = 1'b0;
    wait_cycles(4);
    for (int b = W - 1; b >= 0; b--) begin
      dio_val[board_pkg::DioSdi] = new_key[b];
      dio_val[board_pkg::DioSck] = 1'b0;
      wait_cycles(4);
      old_key[b] = dio_pad[board_pkg::DioSdo];
      dio_val[board_pkg::DioSck] = 1'b1;
      wait_cycles(4);
    end
    dio_val[board_pkg::DioSck] = 1'b0;
    dio_val[board_pkg::DioCsb] = 1'b1;
    wait_cycles(4);
  endtask

  task automatic wait_valid(input logic level, inout int trig_n);
    int guard;
    guard = 0;
    while (mio_pad[board_pkg::MioResultValid] !== level) begin
      if (guard == 100) begin
        abort_run("Result-valid did not change within 100 cycles of start");
      end
      wait_cycles(1);
      guard++;
      if (mio_pad[board_pkg::MioTrigger] === 1'b1) begin
        trig_n++;
      end
    end
  endtask

  task automatic check_op(input logic [W-1:0] din, input logic [W-1:0] k, input logic req);
    logic [W-1:0] exp;
    int           trig_n;
    exp    = model_rounds(din, k);
    trig_n = 0;
    mio_val[board_pkg::MioDataLsb +: W] = din;
    mio_val[board_pkg::MioTrigReq]      = req;
    mio_val[board_pkg::MioStart]        = 1'b1;
    // Valid drops on start, then rises on done
    wait_valid(1'b0, trig_n);
    wait_valid(1'b1, trig_n);
    assert (mio_pad[board_pkg::MioResultLsb +: W] === exp) else
      abort_run($sformatf("ERROR @%0t: result %02h for data %02h key %02h, expected %02h",
                          $time, mio_pad[board_pkg::MioResultLsb +: W], din, k, exp));
    assert (trig_n == (req ? board_pkg::NumRounds : 0)) else
      abort_run($sformatf("ERROR @%0t: trigger high for %0d cycles with request %0b",
                          $time, trig_n, req));
    mio_val[board_pkg::MioStart]   = 1'b0;
    mio_val[board_pkg::MioTrigReq] = 1'b0;
    wait_cycles(3);
  endtask

  // Bound assertions count their failures
  always @(negedge clk) begin
    if (uut.u_sca_board_assertions.fail_cnt != 0) begin
      abort_run("A bound assertion failed, see the message above");
    end
  end

  initial begin
    #(Budget);
    abort_run("Timeout, the tests did not finish within the watchdog budget");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n   = 1'b0;
    mio_en  = '0;
    mio_val = '0;
    mio_en[board_pkg::MioDataLsb +: W] = '1;
    mio_en[board_pkg::MioStart]        = 1'b1;
    mio_en[board_pkg::MioTrigReq]      = 1'b1;
    mio_en[board_pkg::MioJtagEn]       = 1'b1;
    mio_en[board_pkg::MioTrst]         = 1'b1;
    mio_en[board_pkg::MioSrst]         = 1'b1;
    mio_val[board_pkg::MioTrst]        = 1'b1;
    mio_val[board_pkg::MioSrst]        = 1'b1;
    dio_en  = 4'b0111;
    dio_val = '0;
    dio_val[board_pkg::DioCsb] = 1'b1;
    model_key = '0;
    wait_cycles(4);
    rst_n = 1'b1;
    wait_cycles(4);

    assert (mio_pad[board_pkg::MioTrigger] === 1'b0 &&
            mio_pad[board_pkg::MioResultValid] === 1'b0 &&
            dio_pad[board_pkg::DioSdo] === 1'bz) else
      abort_run($sformatf("ERROR @%0t: pins not idle after reset", $time));

    // Two loads, the second reads the first back
    for (int n = 0; n < 2; n++) begin
      next_key = W'($random(seed));
      shift_key(next_key, readback);
      assert (readback === model_key) else
        abort_run($sformatf("ERROR @%0t: key read back %02h, expected %02h",
                            $time, readback, model_key));
      model_key = next_key;
    end

    for (int i = 0; i < 16; i++) begin
      check_op(W'($random(seed)), model_key, i[0]);
    end

    // JTAG bypass through the serial pads
    mio_val[board_pkg::MioJtagEn] = 1'b1;
    wait_cycles(4);
    for (int i = 0; i < 8; i++) begin
      tdi_bit = 1'($random(seed));
      dio_val[board_pkg::DioSdi] = tdi_bit;
      dio_val[board_pkg::DioSck] = 1'b0;
      wait_cycles(4);
      dio_val[board_pkg::DioSck] = 1'b1;
      wait_cycles(4);
      assert (dio_pad[board_pkg::DioSdo] === tdi_bit) else
        abort_run($sformatf("ERROR @%0t: tdo %b, expected %b",
                            $time, dio_pad[board_pkg::DioSdo], tdi_bit));
    end
    dio_val[board_pkg::DioSck] = 1'b0;
    check_op(W'($random(seed)), model_key, 1'b1);

    // System reset from the JTAG pins clears valid and key
    mio_val[board_pkg::MioSrst] = 1'b0;
    wait_cycles(6);
    assert (mio_pad[board_pkg::MioResultValid] === 1'b0) else
      abort_run($sformatf("ERROR @%0t: result-valid still high in system reset", $time));
    mio_val[board_pkg::MioSrst] = 1'b1;
    wait_cycles(6);
    model_key = '0;
    check_op(W'($random(seed)), model_key, 1'b0);
    mio_val[board_pkg::MioJtagEn] = 1'b0;
    wait_cycles(4);

    if (uut.u_sca_board_assertions.fail_cnt == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("A bound assertion failed before the end of the run");
    end
  end

endmodule : tb_sca_board

`default_nettype wire
